// File: hazard_defs.svh
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// datapath widths
`define WORD_W 16
`define REG_W 3

// opcode field
`define OPC_HI 15
`define OPC_LO 11

// register fields of the word
`define RS_HI 10
`define RS_LO 8
`define RT_HI 7
`define RT_LO 5
`define RD_HI 4
`define RD_LO 2

// link register for JAL / JALR
`define LINK_REG 3'd7

// nop is opcode 00001 with all operand bits clear
`define NOP_INST {5'b00001, 11'b0}

`endif

// File: isaPkg.sv
`include "hazard_defs.svh"

package isaPkg;

    // one instruction word as fetched
    typedef logic [`WORD_W-1:0] instWord;

    // register number r0..r7
    typedef logic [`REG_W-1:0] regIdx;

    // major opcode in bits 15..11
    typedef logic [`OPC_HI-`OPC_LO:0] opcode;

    // what the hazard logic needs to know about one word
    typedef struct packed {
        logic  readsRs;
        regIdx rsIdx;
        // second source from bits 7..5
        logic  readsRt;
        regIdx rtIdx;
        logic  regWrt;
        regIdx wrtReg;
        // jumps and branches
        logic  isControl;
        logic  isHalt;
        // siic / RTI
        logic  neverStall;
    } instInfo;

endpackage

// File: pipePkg.sv
package pipePkg;

    // what one stage remembers of its instruction
    typedef struct packed {
        logic          regWrt;
        isaPkg::regIdx wrtReg;
        logic          isControl;
    } stageRec;

    // records of everything issued and still in flight
    typedef struct packed {
        // youngest record that just entered decode
        stageRec d;
        stageRec x;
        stageRec m;
        // oldest record writing back this cycle
        stageRec w;
    } stageSet;

endpackage

// File: instDecode.sv
`include "hazard_defs.svh"

module instDecode (
    input  isaPkg::instWord fetchInst,
    output isaPkg::instInfo info
);
    import isaPkg::*;

    // raw fields
    opcode opc;
    regIdx rsField;
    regIdx rtField;
    regIdx rdField;

    // decoded register use
    logic  readsRs;
    logic  readsRt;
    logic  regWrt;
    regIdx wrtReg;

    assign opc     = fetchInst[`OPC_HI:`OPC_LO];
    assign rsField = fetchInst[`RS_HI:`RS_LO];
    assign rtField = fetchInst[`RT_HI:`RT_LO];
    assign rdField = fetchInst[`RD_HI:`RD_LO];

    // nearly every format reads the first source
    always_comb begin
        casez (opc)
            // halt, nop, siic/RTI
            5'b00000, 5'b00001, 5'b0001?: readsRs = 1'b0;
            // LBI, J, JAL use immediates only
            5'b11000, 5'b00100, 5'b00110: readsRs = 1'b0;
            default: readsRs = 1'b1;
        endcase
    end

    // second source in bits 7..5
    always_comb begin
        casez (opc)
            // ST and STU read the data register
            5'b10000, 5'b10011: readsRt = 1'b1;
            // R-format ALU ops
            5'b1101?, 5'b111??: readsRt = 1'b1;
            default: readsRt = 1'b0;
        endcase
    end

    // destination depends on the format
    always_comb begin
        regWrt = 1'b1;
        wrtReg = rdField;
        casez (opc)
            // R-format and BTR write rd
            5'b1101?, 5'b111??, 5'b11001: wrtReg = rdField;
            // I-format ALU ops and LD write bits 7..5
            5'b010??, 5'b101??, 5'b10001: wrtReg = rtField;
            // STU base update, LBI, SLBI write rs
            5'b10011, 5'b11000, 5'b10010: wrtReg = rsField;
            // link jumps
            5'b0011?: wrtReg = `LINK_REG;
            default: begin
                regWrt = 1'b0;
                wrtReg = '0;
            end
        endcase
    end

    // source indices go out raw and the read flags qualify them
    assign info = '{
        readsRs:    readsRs,
        rsIdx:      rsField,
        readsRt:    readsRt,
        rtIdx:      rtField,
        regWrt:     regWrt,
        wrtReg:     wrtReg,
        // jumps 001xx, branches 011xx
        isControl:  (opc ==? 5'b001??) || (opc ==? 5'b011??),
        isHalt:     (opc == 5'b00000),
        neverStall: (opc ==? 5'b0001?)
    };

endmodule

// File: hazardDet.sv
`include "hazard_defs.svh"

module hazardDet (
    input  logic             arstN,
    input  isaPkg::instWord  fetchInst,
    input  isaPkg::instInfo  fetchInfo,
    input  pipePkg::stageSet stages,
    output isaPkg::instWord  issueInst,
    output logic             pcStall,
    output pipePkg::stageRec issueRec
);
    import isaPkg::*;
    import pipePkg::*;

    // source match terms
    logic rsHit;
    logic rtHit;
    logic dataHazard;

    // control drain terms
    logic ctrlInFlight;
    logic haltDrain;

    logic stallReq;
    logic injectNop;

    // true when this stage will write the given register
    function automatic logic writesReg(stageRec rec, regIdx r);
        return rec.regWrt && (rec.wrtReg == r);
    endfunction

    // W writes before read, so only D, X, M count
    assign rsHit = fetchInfo.readsRs &&
                   (writesReg(stages.d, fetchInfo.rsIdx) ||
                    writesReg(stages.x, fetchInfo.rsIdx) ||
                    writesReg(stages.m, fetchInfo.rsIdx));

    assign rtHit = fetchInfo.readsRt &&
                   (writesReg(stages.d, fetchInfo.rtIdx) ||
                    writesReg(stages.x, fetchInfo.rtIdx) ||
                    writesReg(stages.m, fetchInfo.rtIdx));

    assign dataHazard = rsHit || rtHit;

    // an older jump or branch not yet resolved
    assign ctrlInFlight = stages.d.isControl || stages.x.isControl || stages.m.isControl;

    // halt also waits for the last control to retire
    assign haltDrain = fetchInfo.isHalt && stages.w.isControl;

    // control words only wait on registers; siic/RTI always go
    assign stallReq = !fetchInfo.neverStall &&
                      (dataHazard ||
                       (!fetchInfo.isControl && ctrlInFlight) ||
                       haltDrain);

    // pcStall stays low while in reset
    assign pcStall   = arstN && stallReq;
    assign injectNop = !arstN || stallReq;

    // bubble goes down with an empty record
    assign issueInst = injectNop ? instWord'(`NOP_INST) : fetchInst;
    assign issueRec  = injectNop ? stageRec'('0) :
                       '{regWrt:    fetchInfo.regWrt,
                         wrtReg:    fetchInfo.wrtReg,
                         isControl: fetchInfo.isControl};

endmodule

// File: stageTracker.sv
module stageTracker (
    input  logic             clk,
    input  logic             arstN,
    input  pipePkg::stageRec issueRec,
    output pipePkg::stageSet stages
);
    import pipePkg::*;

    // up to four issued words in flight
    stageSet stageQ;

    // one step down the pipe per clock
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // empty records with no write and no control
            stageQ <= '0;
        end else begin
            stageQ.d <= issueRec;
            stageQ.x <= stageQ.d;
            stageQ.m <= stageQ.x;
            // w falls off the end next clock
            stageQ.w <= stageQ.m;
        end
    end

    assign stages = stageQ;

endmodule

// File: pipeHazardCtl.sv
module pipeHazardCtl (
    input  logic            clk,
    input  logic            arstN,
    input  isaPkg::instWord fetchInst,
    output isaPkg::instWord issueInst,
    output logic            pcStall
);
    import isaPkg::*;
    import pipePkg::*;

    // decoded fetch word
    instInfo fetchInfo;

    // in-flight records and the one entering D
    stageSet stages;
    stageRec issueRec;

    // register use and class of the fetched word
    instDecode uDecode (
        .fetchInst (fetchInst),
        .info      (fetchInfo)
    );

    // stall and nop injection in the same cycle
    hazardDet uDetect (
        .arstN     (arstN),
        .fetchInst (fetchInst),
        .fetchInfo (fetchInfo),
        .stages    (stages),
        .issueInst (issueInst),
        .pcStall   (pcStall),
        .issueRec  (issueRec)
    );

    // D, X, M, W history
    stageTracker uTracker (
        .clk      (clk),
        .arstN    (arstN),
        .issueRec (issueRec),
        .stages   (stages)
    );

endmodule

// File: tb_pipeHazardCtl.sv
`include "hazard_defs.svh"

module tb_pipeHazardCtl;
    import isaPkg::*;
    import pipePkg::*;

    localparam int NumWords = 2000;
    localparam int DrainLimit = 10;
    localparam int RunLimit = 50000;
    localparam instWord NopWord = `NOP_INST;

    logic    clk;
    logic    arstN;
    instWord fetchInst;
    instWord issueInst;
    logic    pcStall;

    integer  seed;
    int      errCount;
    int      passCount;
    int      failCount;

    // reference copy of the D, X, M, W records
    stageSet model;
    // drawn and issued words for the order check
    instWord drawnQ[$];
    instWord issuedQ[$];

    pipeHazardCtl u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .fetchInst (fetchInst),
        .issueInst (issueInst),
        .pcStall   (pcStall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop for the whole run
    initial begin
        #(RunLimit * 10);
        $display("simulation ran past its cycle limit without finishing");
        $display("*** FAILED ***");
        $finish;
    end

    // packs opcode and the rs, rt, rd fields with the low two bits zero
    function automatic instWord encodeWord(opcode o, regIdx rs, regIdx rt, regIdx rd);
        return {o, rs, rt, rd, 2'b00};
    endfunction

    // what the issued word leaves in the D record
    function automatic stageRec modelRec(instWord w);
        opcode   o;
        stageRec r;
        o = w[`OPC_HI:`OPC_LO];
        r = '0;
        if (o[4:1] == 4'b1101 || o[4:2] == 3'b111 || o == 5'b11001) begin
            r.regWrt = 1'b1;
            r.wrtReg = w[4:2];
        end else if (o[4:2] == 3'b010 || o[4:2] == 3'b101 || o == 5'b10001) begin
            r.regWrt = 1'b1;
            r.wrtReg = w[7:5];
        end else if (o == 5'b10011 || o == 5'b11000 || o == 5'b10010) begin
            r.regWrt = 1'b1;
            r.wrtReg = w[10:8];
        end else if (o[4:1] == 4'b0011) begin
            // link jumps write r7
            r.regWrt = 1'b1;
            r.wrtReg = 3'd7;
        end
        r.isControl = (o[4:2] == 3'b001) || (o[4:2] == 3'b011);
        return r;
    endfunction

    // W writes before the read and is left out
    function automatic logic inFlightWrites(stageSet s, regIdx r);
        return (s.d.regWrt && s.d.wrtReg == r) ||
               (s.x.regWrt && s.x.wrtReg == r) ||
               (s.m.regWrt && s.m.wrtReg == r);
    endfunction

    function automatic logic modelStall(instWord w, stageSet s);
        opcode   o;
        stageRec own;
        logic    rdRs;
        logic    rdRt;
        logic    hazard;
        logic    ctrlDrain;
        o = w[`OPC_HI:`OPC_LO];
        own = modelRec(w);
        rdRs = !(o == 5'b00000 || o == 5'b00001 || o[4:1] == 4'b0001 ||
                 o == 5'b11000 || o == 5'b00100 || o == 5'b00110);
        rdRt = o == 5'b10000 || o == 5'b10011 || o[4:1] == 4'b1101 || o[4:2] == 3'b111;
        hazard = (rdRs && inFlightWrites(s, w[10:8])) || (rdRt && inFlightWrites(s, w[7:5]));
        ctrlDrain = !own.isControl && (s.d.isControl || s.x.isControl || s.m.isControl);
        // siic and RTI
        if (o[4:1] == 4'b0001) begin
            return 1'b0;
        end
        return hazard || ctrlDrain || (o == 5'b00000 && s.w.isControl);
    endfunction

    // weighted opcode pick with a small register range
    function automatic instWord drawWord(logic [31:0] r);
        opcode o;
        case (r[3:0])
            4'd0:    o = 5'b00000;
            4'd1:    o = 5'b00001;
            4'd2:    o = 5'b00010;
            4'd3:    o = 5'b00011;
            4'd4:    o = 5'b00100;
            4'd5:    o = 5'b00101;
            4'd6:    o = 5'b00110;
            4'd7:    o = 5'b01101;
            4'd8:    o = 5'b01000;
            4'd9:    o = 5'b10001;
            4'd10:   o = 5'b10000;
            4'd11:   o = 5'b10011;
            4'd12:   o = 5'b11000;
            4'd13:   o = 5'b11001;
            4'd14:   o = 5'b11011;
            default: o = r[31:27];
        endcase
        return {o, 1'b0, r[5:4], 1'b0, r[7:6], 1'b0, r[9:8], r[11:10]};
    endfunction

    task automatic checkInst(input string name, input instWord got, input instWord exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkStall(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // drive on the falling edge and compare in the low phase
    task automatic runCycle(input instWord w, output logic stalled);
        logic    expStall;
        stageRec nextRec;
        @(negedge clk);
        fetchInst = w;
        #2;
        expStall = modelStall(w, model);
        checkStall("pcStall", pcStall, expStall);
        checkInst("issueInst", issueInst, expStall ? NopWord : w);
        if (!pcStall) begin
            issuedQ.push_back(issueInst);
        end
        nextRec = expStall ? stageRec'('0) : modelRec(w);
        stalled = pcStall;
        // model shifts after the rising edge
        @(posedge clk);
        model.w = model.m;
        model.m = model.x;
        model.x = model.d;
        model.d = nextRec;
    endtask

    // hold one word at fetch until it issues
    task automatic issueWord(input instWord w, output int stalls);
        logic stalled;
        int   n;
        stalls = 0;
        stalled = 1'b1;
        n = 0;
        while (stalled && n < DrainLimit) begin
            runCycle(w, stalled);
            if (stalled) begin
                stalls++;
            end
            n++;
        end
        if (stalled) begin
            errCount++;
            $display("word %h still stalled after %0d cycles, the pipeline failed to drain",
                     w, DrainLimit);
        end
    endtask

    task automatic expectStalls(input instWord w, input int exp);
        int n;
        issueWord(w, n);
        if (n != exp) begin
            errCount++;
            $display("[FAIL] t=%0t stall cycles of %h got %0d expected %0d", $time, w, n, exp);
        end
    endtask

    // four nops push every record out
    task automatic drain();
        int n;
        repeat (4) issueWord(NopWord, n);
    endtask

    task automatic endTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errCount - errBefore);
        end
    endtask

    initial begin
        int          errBefore;
        int          n;
        logic [31:0] r;
        instWord     w;
        seed = 32'h3309ff12;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        model = '0;
        arstN = 1'b0;
        // a writing word at fetch still gives a nop
        fetchInst = encodeWord(5'b11011, 3'd1, 3'd2, 3'd3);

        errBefore = errCount;
        repeat (4) begin
            @(negedge clk);
            #2;
            checkInst("issueInst", issueInst, NopWord);
            checkStall("pcStall", pcStall, 1'b0);
        end
        @(negedge clk);
        arstN = 1'b1;
        fetchInst = NopWord;
        #2;
        checkInst("issueInst", issueInst, NopWord);
        checkStall("pcStall", pcStall, 1'b0);
        expectStalls(encodeWord(5'b11011, 3'd1, 3'd2, 3'd3), 0);
        drain();
        endTest("reset", errBefore);

        // LD r1 followed by a reader of r1 and a reader of r4 through rt
        errBefore = errCount;
        expectStalls(encodeWord(5'b10001, 3'd2, 3'd1, 3'd0), 0);
        expectStalls(encodeWord(5'b11011, 3'd1, 3'd3, 3'd4), 3);
        expectStalls(encodeWord(5'b10000, 3'd5, 3'd4, 3'd0), 3);
        drain();
        endTest("register hazard", errBefore);

        errBefore = errCount;
        expectStalls(encodeWord(5'b00100, 3'd0, 3'd0, 3'd0), 0);
        expectStalls(encodeWord(5'b11011, 3'd5, 3'd6, 3'd2), 3);
        drain();
        // branch right behind a jump goes
        expectStalls(encodeWord(5'b00100, 3'd0, 3'd0, 3'd0), 0);
        expectStalls(encodeWord(5'b01101, 3'd3, 3'd0, 3'd0), 0);
        drain();
        // but waits on a register
        expectStalls(encodeWord(5'b10001, 3'd0, 3'd3, 3'd0), 0);
        expectStalls(encodeWord(5'b01101, 3'd3, 3'd0, 3'd0), 3);
        drain();
        endTest("control drain", errBefore);

        // halt waits for D, X, M and W
        errBefore = errCount;
        expectStalls(encodeWord(5'b00100, 3'd0, 3'd0, 3'd0), 0);
        expectStalls(encodeWord(5'b00000, 3'd0, 3'd0, 3'd0), 4);
        drain();
        endTest("halt", errBefore);

        // siic and RTI right behind a jump still go
        errBefore = errCount;
        expectStalls(encodeWord(5'b10001, 3'd0, 3'd2, 3'd0), 0);
        expectStalls(encodeWord(5'b00100, 3'd0, 3'd0, 3'd0), 0);
        expectStalls(encodeWord(5'b00010, 3'd2, 3'd2, 3'd2), 0);
        expectStalls(encodeWord(5'b00011, 3'd0, 3'd0, 3'd0), 0);
        drain();
        expectStalls(encodeWord(5'b11011, 3'd1, 3'd1, 3'd1), 0);
        drain();
        endTest("never stall and pass through", errBefore);

        errBefore = errCount;
        drawnQ.delete();
        issuedQ.delete();
        for (int i = 0; i < NumWords; i++) begin
            r = $random(seed);
            w = drawWord(r);
            drawnQ.push_back(w);
            issueWord(w, n);
        end
        // each drawn word exactly once and in order
        if (issuedQ.size() != drawnQ.size()) begin
            errCount++;
            $display("issued %0d words but %0d were fetched", issuedQ.size(), drawnQ.size());
        end else begin
            foreach (drawnQ[i]) begin
                checkInst("issued order", issuedQ[i], drawnQ[i]);
            end
        end
        endTest("random stream", errBefore);

        $display("tests ok %0d, tests failing %0d, check errors %0d",
                 passCount, failCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: pipeHazardCtl.f
+incdir+.
isaPkg.sv
pipePkg.sv
instDecode.sv
hazardDet.sv
stageTracker.sv
pipeHazardCtl.sv
tb_pipeHazardCtl.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

# build the testbench and the DUT into one binary
verilator --binary --timing \
    -f pipeHazardCtl.f \
    --top-module tb_pipeHazardCtl \
    -o sim_pipeHazardCtl

./obj_dir/sim_pipeHazardCtl | tee "$LOG"

# the testbench prints the fail message on any error or timeout
if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure, see $LOG"
